//--- build.f
common/rename_pkg.sv
common/ckpt_pkg.sv
free_list/free_list.sv
rat/rat_table.sv
logic/ckpt_arbiter.sv
logic/ckpt_store.sv
logic/rename_top.sv
verif/rename_checker.sv
verif/rename_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module rename_tb -o rename_sim

./obj_dir/rename_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

//--- verif/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb
    import rename_pkg::*, ckpt_pkg::*;
();

    localparam int          PERIOD       = 10;
    localparam int          RESET_CYCLES = 5;
    localparam logic [15:0] SEED         = 16'd92;
    localparam int          N_OPS        = 600;
    localparam int          WATCHDOG_NS  = N_OPS * 5 * PERIOD;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        rename_en;
    arch_t       rename_arch;
    logic        save;
    logic        restore;
    page_t       ckpt_page;
    tag_t        alloc_tag;
    tag_t        prev_tag;
    logic        rename_done;
    logic        ckpt_busy;
    int          tag_errs;
    int          ctrl_errs;
    logic [15:0] lfsr;

    rename_top dut_i (.*);

    rename_checker check_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[6:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic drive(input logic ren, input arch_t arch, input logic sv, input logic rs,
                         input page_t pg, input logic fl);
        @(posedge clk);
        rename_en   <= ren;
        rename_arch <= arch;
        save        <= sv;
        restore     <= rs;
        ckpt_page   <= pg;
        flush       <= fl;
    endtask

    task automatic idle();
        drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic rename_ordered(input int n);
        for (int i = 0; i < n; i++) begin
            drive(1'b1, arch_t'(i), 1'b0, 1'b0, '0, 1'b0);
        end
    endtask

    task automatic rename_random(input int n);
        for (int i = 0; i < n; i++) begin
            if (rand_bits(1) != 0) begin
                drive(1'b1, arch_t'(rand_bits(5)), 1'b0, 1'b0, '0, 1'b0);
            end else begin
                idle();
            end
        end
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (ckpt_busy) begin
            @(posedge clk);
        end
    endtask

    // renames pushed during busy must be dropped
    task automatic checkpoint(input logic sv, input page_t pg, input int busy_renames);
        drive(1'b0, '0, sv, !sv, pg, 1'b0);
        for (int k = 0; k < busy_renames; k++) begin
            drive(1'b1, arch_t'(rand_bits(5)), 1'b0, 1'b0, '0, 1'b0);
        end
        idle();
        wait_idle();
    endtask

    task automatic flush_during_restore(input page_t pg);
        drive(1'b0, '0, 1'b0, 1'b1, pg, 1'b0);
        idle();
        drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b1); // lands in the second busy cycle
        idle();
        wait_idle();
    endtask

    initial begin
        page_t order [CKPT_PAGES];
        order       = '{3'd5, 3'd0, 3'd7, 3'd2, 3'd6, 3'd1, 3'd4, 3'd3};
        clk         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        rename_en   = 1'b0;
        rename_arch = '0;
        save        = 1'b0;
        restore     = 1'b0;
        ckpt_page   = '0;
        lfsr        = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        rename_ordered(32);
        rename_random(200);
        checkpoint(1'b1, 3'd3, 0);
        rename_random(40);
        checkpoint(1'b0, 3'd3, 0);
        rename_random(40);
        for (int p = 0; p < CKPT_PAGES; p++) begin
            checkpoint(1'b1, page_t'(p), 2);
            rename_random(10);
        end
        for (int i = 0; i < CKPT_PAGES; i++) begin
            checkpoint(1'b0, order[i], 2);
            rename_random(8);
        end
        rename_random(20);
        drive(1'b1, arch_t'(rand_bits(5)), 1'b0, 1'b0, '0, 1'b1); // flush beats the rename
        rename_ordered(32);
        flush_during_restore(3'd6);
        rename_ordered(32);
        repeat (4) idle();
        @(negedge clk); // checker has finished its last edge
        $display("errors: tags %0d, control %0d", tag_errs, ctrl_errs);
        if (tag_errs == 0 && ctrl_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns, stopping", WATCHDOG_NS);
        $display("errors: tags %0d, control %0d", tag_errs, ctrl_errs);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rename_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rename_checker
    import rename_pkg::*, ckpt_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,
    input  wire logic  rename_en,
    input  wire arch_t rename_arch,
    input  wire logic  save,
    input  wire logic  restore,
    input  wire page_t ckpt_page,
    input  wire tag_t  alloc_tag,
    input  wire tag_t  prev_tag,
    input  wire logic  rename_done,
    input  wire logic  ckpt_busy,
    output int         tag_errs,
    output int         ctrl_errs
);

    typedef struct packed {
        tag_t alloc;
        tag_t prev;
    } tag_pair_t;

    typedef enum {PH_IDLE, PH_SAVE_RAT, PH_SAVE_FL, PH_RD_RAT, PH_RD_FL, PH_RD_WAIT} phase_e;

    tag_t      m_ring [FL_DEPTH];
    fl_idx_t   m_head;
    tag_t      m_map [ARCH_REGS];
    tag_t      pg_ring [CKPT_PAGES][FL_DEPTH];
    fl_idx_t   pg_head [CKPT_PAGES];
    tag_t      pg_map [CKPT_PAGES][ARCH_REGS];
    phase_e    phase;
    page_t     cur_pg;
    logic      exp_done;
    tag_pair_t exp_pair;
    int        n_tag = 0;
    int        n_ctrl = 0;

    assign tag_errs  = n_tag;
    assign ctrl_errs = n_ctrl;

    // fresh tag from the head, displaced tag from the map
    function automatic tag_pair_t ref_rename(input arch_t a);
        tag_pair_t p;
        p.alloc = m_ring[m_head];
        p.prev  = m_map[a];
        return p;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < FL_DEPTH; i++) begin
            m_ring[i] = tag_t'(FL_RESET_BASE + i);
        end
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_map[i] = tag_t'(i);
        end
        m_head   = '0;
        phase    = PH_IDLE;
        exp_done = 1'b0;
    endtask

    task automatic compare(input string name, input logic [7:0] expv, input logic [7:0] gotv,
                           input logic is_tag);
        if (gotv !== expv) begin
            $display("Error %s expected %h got %h at %0t", name, expv, gotv, $time);
            if (is_tag) begin
                n_tag++;
            end else begin
                n_ctrl++;
            end
        end
    endtask

    always @(posedge clk) begin : model_step
        tag_pair_t pair;
        if (!arst_n) begin
            reset_model();
        end else begin
            compare("rename_done", 8'(exp_done), 8'(rename_done), 1'b0);
            compare("ckpt_busy", 8'(phase != PH_IDLE), 8'(ckpt_busy), 1'b0);
            if (exp_done) begin
                compare("alloc_tag", exp_pair.alloc, alloc_tag, 1'b1);
                compare("prev_tag", exp_pair.prev, prev_tag, 1'b1);
            end
            // a granted store write lands even when flush hits the same edge
            if (phase == PH_SAVE_RAT) begin
                pg_map[cur_pg] = m_map;
            end
            if (phase == PH_SAVE_FL) begin
                pg_ring[cur_pg] = m_ring;
                pg_head[cur_pg] = m_head;
            end
            exp_done = 1'b0;
            if (flush) begin
                reset_model();
            end else begin
                case (phase)
                    PH_IDLE: begin
                        if (rename_en && !save && !restore) begin
                            pair               = ref_rename(rename_arch);
                            m_map[rename_arch] = pair.alloc;
                            m_ring[m_head]     = pair.prev; // swap into the popped slot
                            m_head             = m_head + fl_idx_t'(1);
                            exp_pair           = pair;
                            exp_done           = 1'b1;
                        end else if (save) begin
                            phase  = PH_SAVE_RAT;
                            cur_pg = ckpt_page;
                        end else if (restore) begin
                            phase  = PH_RD_RAT;
                            cur_pg = ckpt_page;
                        end
                    end
                    PH_SAVE_RAT: phase = PH_SAVE_FL;
                    PH_RD_RAT:   phase = PH_RD_FL;
                    PH_RD_FL: begin
                        m_map = pg_map[cur_pg]; // read data valid one cycle after request
                        phase = PH_RD_WAIT;
                    end
                    PH_RD_WAIT: begin
                        m_ring = pg_ring[cur_pg];
                        m_head = pg_head[cur_pg];
                        phase  = PH_IDLE;
                    end
                    default: phase = PH_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top
    import rename_pkg::*, ckpt_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,
    input  wire logic  rename_en,
    input  wire arch_t rename_arch,
    input  wire logic  save,
    input  wire logic  restore,
    input  wire page_t ckpt_page,
    output tag_t       alloc_tag,
    output tag_t       prev_tag,
    output logic       rename_done,
    output logic       ckpt_busy
);

    logic      rename_ok;
    tag_t      head_tag;
    tag_t      cur_tag;
    fl_snap_t  fl_snap;
    fl_snap_t  rd_fl;
    rat_snap_t rat_snap;
    rat_snap_t rd_rat;
    ckpt_req_t req;
    logic      load_rat;
    logic      load_fl;

    free_list free_list_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .rename_ok (rename_ok),
        .cur_tag   (cur_tag),
        .head_tag  (head_tag),
        .fl_snap   (fl_snap),
        .rd_fl     (rd_fl),
        .load_fl   (load_fl),
        .alloc_tag (alloc_tag)
    );

    rat_table rat_table_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .rename_ok   (rename_ok),
        .rename_arch (rename_arch),
        .head_tag    (head_tag),
        .cur_tag     (cur_tag),
        .rat_snap    (rat_snap),
        .rd_rat      (rd_rat),
        .load_rat    (load_rat),
        .prev_tag    (prev_tag),
        .rename_done (rename_done)
    );

    ckpt_arbiter ckpt_arbiter_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .rename_en (rename_en),
        .save      (save),
        .restore   (restore),
        .ckpt_page (ckpt_page),
        .rename_ok (rename_ok),
        .req       (req),
        .load_rat  (load_rat),
        .load_fl   (load_fl),
        .ckpt_busy (ckpt_busy)
    );

    ckpt_store ckpt_store_i (
        .clk      (clk),
        .req      (req),
        .rat_snap (rat_snap),
        .fl_snap  (fl_snap),
        .rd_rat   (rd_rat),
        .rd_fl    (rd_fl)
    );

endmodule

`default_nettype wire

//--- logic/ckpt_store.sv
`timescale 1ns/10ps
`default_nettype none

module ckpt_store
    import ckpt_pkg::*;
(
    input  wire logic      clk,
    input  wire ckpt_req_t req,
    input  wire rat_snap_t rat_snap,
    input  wire fl_snap_t  fl_snap,
    output rat_snap_t      rd_rat,
    output fl_snap_t       rd_fl
);

    rat_snap_t rat_mem [CKPT_PAGES];
    fl_snap_t  fl_mem  [CKPT_PAGES];

    logic rat_sel;
    logic fl_sel;

    // one port, region picks which array sees the access
    assign rat_sel = req.valid && (req.region == REGION_RAT);
    assign fl_sel  = req.valid && (req.region == REGION_FL);

    always_ff @(posedge clk) begin
        if (rat_sel && req.write) begin
            rat_mem[req.page] <= rat_snap;
        end
        if (fl_sel && req.write) begin
            fl_mem[req.page] <= fl_snap;
        end
    end

    always_ff @(posedge clk) begin
        if (rat_sel && !req.write) begin
            rd_rat <= rat_mem[req.page];
        end
        if (fl_sel && !req.write) begin
            rd_fl <= fl_mem[req.page];
        end
    end

endmodule

`default_nettype wire

//--- logic/ckpt_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ckpt_arbiter
    import ckpt_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,
    input  wire logic  rename_en,
    input  wire logic  save,
    input  wire logic  restore,
    input  wire page_t ckpt_page,
    output logic       rename_ok,
    output ckpt_req_t  req,
    output logic       load_rat,
    output logic       load_fl,
    output logic       ckpt_busy
);

    typedef enum logic [2:0] {
        IDLE,
        SAVE_RAT,
        SAVE_FL,
        RD_RAT,
        RD_FL,
        RD_WAIT
    } state_e;

    state_e state;
    page_t  page_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE; // a write granted this cycle still lands
        end else begin
            case (state)
                IDLE: begin
                    if (save) begin
                        state <= SAVE_RAT; // save wins over restore
                    end else if (restore) begin
                        state <= RD_RAT;
                    end
                end
                SAVE_RAT: state <= SAVE_FL;
                RD_RAT:   state <= RD_FL;
                RD_FL:    state <= RD_WAIT;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && (save || restore)) begin
            page_q <= ckpt_page;
        end
    end

    assign ckpt_busy = (state != IDLE);
    assign rename_ok = rename_en && !ckpt_busy && !save && !restore && !flush;

    assign req.valid  = ckpt_busy && (state != RD_WAIT);
    assign req.write  = (state == SAVE_RAT) || (state == SAVE_FL);
    assign req.region = (state == SAVE_FL || state == RD_FL) ? REGION_FL : REGION_RAT;
    assign req.page   = page_q;

    // store read data shows up one cycle after the request
    assign load_rat = (state == RD_FL);
    assign load_fl  = (state == RD_WAIT);

endmodule

`default_nettype wire

//--- rat/rat_table.sv
`timescale 1ns/10ps
`default_nettype none

module rat_table
    import rename_pkg::*, ckpt_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      flush,
    input  wire logic      rename_ok,
    input  wire arch_t     rename_arch,
    input  wire tag_t      head_tag,
    output tag_t           cur_tag,
    output rat_snap_t      rat_snap,
    input  wire rat_snap_t rd_rat,
    input  wire logic      load_rat,
    output tag_t           prev_tag,
    output logic           rename_done
);

    typedef tag_t [ARCH_REGS-1:0] map_t;

    map_t map;

    // identity mapping, arch reg i lives in tag i
    function automatic map_t base_map();
        map_t m;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m[i] = tag_t'(i);
        end
        return m;
    endfunction

    assign cur_tag      = map[rename_arch]; // tag about to be displaced
    assign rat_snap.map = map;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map <= base_map();
        end else if (flush) begin
            map <= base_map();
        end else if (load_rat) begin
            map <= rd_rat.map;
        end else if (rename_ok) begin
            map[rename_arch] <= head_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rename_done <= 1'b0;
        end else if (flush) begin
            rename_done <= 1'b0;
        end else begin
            rename_done <= rename_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_ok) begin
            prev_tag <= cur_tag;
        end
    end

endmodule

`default_nettype wire

//--- free_list/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list
    import rename_pkg::*, ckpt_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     flush,
    input  wire logic     rename_ok,
    input  wire tag_t     cur_tag,
    output tag_t          head_tag,
    output fl_snap_t      fl_snap,
    input  wire fl_snap_t rd_fl,
    input  wire logic     load_fl,
    output tag_t          alloc_tag
);

    typedef tag_t [FL_DEPTH-1:0] ring_t;

    ring_t   ring;
    fl_idx_t head;

    // slot i starts out holding tag 32+i
    function automatic ring_t base_ring();
        ring_t r;
        for (int i = 0; i < FL_DEPTH; i++) begin
            r[i] = tag_t'(FL_RESET_BASE + i);
        end
        return r;
    endfunction

    assign head_tag = ring[head]; // next tag to hand out

    assign fl_snap.ring = ring;
    assign fl_snap.head = head;

    // the popped slot takes the displaced tag, so the ring
    // always holds exactly the set of free tags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ring <= base_ring();
            head <= '0;
        end else if (flush) begin
            ring <= base_ring();
            head <= '0;
        end else if (load_fl) begin
            ring <= rd_fl.ring;
            head <= rd_fl.head;
        end else if (rename_ok) begin
            ring[head] <= cur_tag;
            head       <= head + 1'b1; // wraps at 128
        end
    end

    always_ff @(posedge clk) begin
        if (rename_ok) begin
            alloc_tag <= head_tag;
        end
    end

endmodule

`default_nettype wire

//--- common/ckpt_pkg.sv
`default_nettype none

package ckpt_pkg;

    import rename_pkg::*;

    localparam int CKPT_PAGES = 8;

    typedef logic [$clog2(CKPT_PAGES)-1:0] page_t;

    typedef enum logic {
        REGION_RAT = 1'b0,
        REGION_FL  = 1'b1
    } ckpt_region_e;

    // whole ring plus head, 1031 bits
    typedef struct packed {
        tag_t [FL_DEPTH-1:0] ring;
        fl_idx_t             head;
    } fl_snap_t;

    typedef struct packed {
        tag_t [ARCH_REGS-1:0] map;
    } rat_snap_t;

    typedef struct packed {
        logic         valid;
        logic         write; // 1 = save, 0 = read back
        ckpt_region_e region;
        page_t        page;
    } ckpt_req_t;

endpackage

`default_nettype wire

//--- common/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int FL_DEPTH      = 128;
    localparam int ARCH_REGS     = 32;
    localparam int FL_RESET_BASE = 32; // first tag past the initial arch mapping

    // physical register tag
    typedef logic [7:0] tag_t;

    // architectural register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_t;

    // free list ring index, wraps at FL_DEPTH
    typedef logic [$clog2(FL_DEPTH)-1:0] fl_idx_t;

endpackage

`default_nettype wire
